/* dv/fizzle_display_tb.sv */
/* fizzle display testbench
   loads palette and image from the input file, then follows the picture
   through image display, fizzle fade and a final palette change */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module fizzle_display_tb;

    localparam int PAL_SIZE     = 1 << `CIDXW;
    localparam int PIX_FRAME    = `H_ACTIVE * `V_ACTIVE;   // de cycles per frame
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int LOAD_CYCLES  = PAL_SIZE + `FB_PIXELS;
    localparam int FADE_LIMIT   = 63 * `FADE_RATE + 2;     // full LFSR cycle
    localparam int TIMEOUT      = LOAD_CYCLES + 15 * FRAME_CYCLES + 900;

    // what a frame is expected to show
    localparam int M_IMAGE    = 0;
    localparam int M_FADING   = 1;
    localparam int M_ALLFADE  = 2;
    localparam int M_MIXED    = 3;  // palette rewritten inside the frame
    localparam int M_RECOLOUR = 4;

    logic                 clk_sys;
    logic                 rst_n;
    fizzle_pkg::fb_wr_t   img_wr;
    logic                 pal_we;
    logic [`CIDXW-1:0]    pal_idx;
    fizzle_pkg::rgb_t     pal_rgb;
    fizzle_pkg::pix_out_t pix;
    logic                 fade_done;

    logic [11:0]       stim [LOAD_CYCLES];   // palette words, then image indices
    fizzle_pkg::rgb_t  pal_model [PAL_SIZE];
    logic [`CIDXW-1:0] img_model [`FB_PIXELS];
    fizzle_pkg::rgb_t  frame_buf [PIX_FRAME]; // captured active pixels

    int   errors, checks, cycles;
    int   frame_no, pcount, hs_count, cur_mode;
    int   image_frames, fading_frames, allfade_frames, recolour_frames;
    int   fade_start;                        // cycle of the first fading pixel
    logic fade_seen, recoloured, started;
    logic vsync_q, hsync_q;

    tb_clock tb_clock_inst (
        .clk_sys (clk_sys)
    );

    fizzle_display fizzle_display_inst (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .img_wr    (img_wr),
        .pal_we    (pal_we),
        .pal_idx   (pal_idx),
        .pal_rgb   (pal_rgb),
        .pix       (pix),
        .fade_done (fade_done)
    );

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic string pix_name(input string sig, input int x, input int y);
        return $sformatf("%s[%0d,%0d]", sig, x, y);
    endfunction

    task automatic write_pal(input int idx, input fizzle_pkg::rgb_t rgb);
        @(posedge clk_sys);
        #1;
        pal_we         = 1'b1;
        pal_idx        = `CIDXW'(idx);
        pal_rgb        = rgb;
        pal_model[idx] = rgb;
    endtask

    task automatic write_img(input int addr, input logic [`CIDXW-1:0] cidx);
        @(posedge clk_sys);
        #1;
        pal_we          = 1'b0;
        img_wr.we       = 1'b1;
        img_wr.addr     = `FB_ADDRW'(addr);
        img_wr.cidx     = cidx;
        img_model[addr] = cidx;
    endtask

    // expectation for the frame that begins here
    task automatic start_frame();
        started  = 1'b1;
        frame_no++;
        pcount   = 0;
        hs_count = 0;
        if (recoloured) begin
            cur_mode = M_RECOLOUR;
        end else if (fade_done) begin
            cur_mode = M_ALLFADE;
        end else if (frame_no < `FADE_WAIT) begin
            cur_mode = M_IMAGE;            // fade not started yet
        end else begin
            cur_mode = M_FADING;
        end
    endtask

    task automatic end_frame();
        int x;
        int y;
        int corner;
        fizzle_pkg::rgb_t orig_c;
        fizzle_pkg::rgb_t fade_c;
        check_val("de_cycles_per_frame", pcount, PIX_FRAME);
        check_val("hsync_pulses_per_frame", hs_count, `V_TOTAL);
        fade_c = pal_model[`FADE_CIDX];
        for (int p = 0; p < PIX_FRAME; p++) begin
            x      = p % `H_ACTIVE;
            y      = p / `H_ACTIVE;
            orig_c = pal_model[img_model[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
            corner = (y / `FB_SCALE) * `FB_SCALE * `H_ACTIVE + (x / `FB_SCALE) * `FB_SCALE;
            case (cur_mode)
                M_IMAGE: check_val(pix_name("pix.rgb", x, y), frame_buf[p], orig_c);
                M_FADING: begin
                    // either untouched or already faded
                    if (frame_buf[p] !== orig_c && frame_buf[p] !== fade_c) begin
                        check_val(pix_name("pix.rgb", x, y), frame_buf[p], orig_c);
                    end
                    check_val(pix_name("pix.rgb_block", x, y), frame_buf[p],
                              frame_buf[corner]);  // scaled block stays uniform
                end
                M_ALLFADE, M_RECOLOUR: begin
                    check_val(pix_name("pix.rgb", x, y), frame_buf[p], fade_c);
                end
                default: ;                 // mixed palette, content not defined
            endcase
        end
        case (cur_mode)
            M_IMAGE:    image_frames++;
            M_FADING:   fading_frames++;
            M_ALLFADE:  allfade_frames++;
            M_RECOLOUR: recolour_frames++;
            default:    ;
        endcase
    endtask

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
    end

    // output monitor, sampled mid cycle where pix is stable
    always @(negedge clk_sys) begin
        if (rst_n) begin
            if (vsync_q && !pix.vsync) begin  // falling vsync ends a frame
                if (started) begin
                    end_frame();
                end
                start_frame();
            end
            if (started) begin
                if (pix.hsync && !hsync_q) begin
                    hs_count++;
                end
                if (pix.de) begin
                    if (pcount < PIX_FRAME) begin
                        frame_buf[pcount] = pix.rgb;
                    end
                    if (frame_no == `FADE_WAIT && pcount == 0) begin
                        fade_start = cycles;       // frame pulse that starts the fade
                    end
                    pcount++;
                end else begin
                    check_val("pix.rgb", pix.rgb, 0);  // black in blanking
                end
            end
            if (fade_done && !fade_seen) begin
                fade_seen = 1'b1;
                if (fade_start < 0) begin
                    errors++;
                    $display("fade_done went high before the fade could start");
                end else begin
                    check_val("fade_done_in_time", (cycles - fade_start) <= FADE_LIMIT, 1);
                end
            end
            vsync_q = pix.vsync;
            hsync_q = pix.hsync;
        end
    end

    initial begin
        rst_n      = 1'b0;
        img_wr     = '0;
        pal_we     = 1'b0;
        pal_idx    = '0;
        pal_rgb    = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        frame_no   = 0;
        pcount     = 0;
        hs_count   = 0;
        cur_mode   = M_IMAGE;
        fade_start = -1;
        fade_seen  = 1'b0;
        recoloured = 1'b0;
        started    = 1'b0;
        vsync_q    = 1'b0;
        hsync_q    = 1'b0;
        $readmemh("dv/fizzle_input.mem", stim);

        repeat (3) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;
        @(negedge clk_sys);
        check_val("pix.de", pix.de, 0);
        check_val("pix.hsync", pix.hsync, 0);
        check_val("pix.vsync", pix.vsync, 0);
        check_val("fade_done", fade_done, 0);

        for (int i = 0; i < PAL_SIZE; i++) begin
            write_pal(i, stim[i]);
        end
        for (int i = 0; i < `FB_PIXELS; i++) begin
            write_img(i, stim[PAL_SIZE + i][`CIDXW-1:0]);
        end
        @(posedge clk_sys);
        #1;
        img_wr.we = 1'b0;

        // run through the fade until one frame is fully faded
        while (allfade_frames == 0) begin
            @(posedge clk_sys);
        end
        write_pal(`FADE_CIDX, ~pal_model[`FADE_CIDX]);  // new fade colour
        recoloured = 1'b1;
        cur_mode   = M_MIXED;
        @(posedge clk_sys);
        #1;
        pal_we = 1'b0;
        while (recolour_frames == 0) begin
            @(posedge clk_sys);
        end

        check_val("image_frames", image_frames, `FADE_WAIT - 1);
        check_val("fading_frames_seen", fading_frames != 0, 1);
        check_val("fade_done", fade_done, 1);  // stays high once set
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk_sys);
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/fizzle_input.mem */
// lines 0..15: palette entries as 12-bit rgb, r in the top nibble
// lines 16..47: framebuffer colour indices, row major, 8 per row
// palette
000
00f
0f0
0ff
f00
f0f
ff0
888
fff
123
456
789
abc
def
5a5
a5a
// image row 0
1
2
3
4
5
6
8
9
// image row 1
a
b
c
d
e
f
0
1
// image row 2
2
4
6
8
a
c
e
0
// image row 3
3
5
9
b
d
f
1
2

/* dv/tb_clock.sv */
/* testbench clock source
   free running clk_sys, 10 ns period */
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD = 10.0  // ns
) (
    output logic clk_sys
);

    initial clk_sys = 1'b0;

    always #(PERIOD / 2.0) clk_sys = ~clk_sys;  // first rising edge at 5 ns

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/fizzle_pkg.sv
src/display_timing.sv
src/fb_ram.sv
src/fade_ctrl.sv
src/line_scaler.sv
src/clut.sv
src/fizzle_display.sv
dv/tb_clock.sv
dv/fizzle_display_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fizzle display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f \
    --top-module fizzle_display_tb -o fizzle_sim

./obj_dir/fizzle_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

/* src/clut.sv */
/* colour lookup table
   writable 16 entry palette, registered lookup with sync kept aligned */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module clut (
    input  wire logic              clk_sys,
    input  wire logic              rst_n,
    input  wire logic              pal_we,
    input  wire logic [`CIDXW-1:0] pal_idx,
    input  wire fizzle_pkg::rgb_t  pal_rgb,
    input  wire logic [`CIDXW-1:0] cidx,
    input  wire fizzle_pkg::scan_t scan_in,
    output fizzle_pkg::pix_out_t   pix
);

    fizzle_pkg::rgb_t pal [1 << `CIDXW];

    always_ff @(posedge clk_sys) begin
        if (pal_we) begin
            pal[pal_idx] <= pal_rgb;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.rgb   <= scan_in.de ? pal[cidx] : '0;  // black in blanking
            pix.de    <= scan_in.de;
            pix.hsync <= scan_in.hsync;
            pix.vsync <= scan_in.vsync;
        end
    end

endmodule

`default_nettype wire

/* src/display_timing.sv */
/* display timing generator
   screen position counters with sync, data enable, line and frame pulses */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module display_timing (
    input  wire logic          clk_sys,
    input  wire logic          rst_n,
    output fizzle_pkg::scan_t  scan
);

    logic [`CORDW-1:0] nx, ny;  // position of the coming cycle

    always_comb begin
        if (scan.sx == `CORDW'(`H_TOTAL - 1)) begin
            nx = '0;
            // wrap to the top after the last line
            ny = (scan.sy == `CORDW'(`V_TOTAL - 1)) ? '0 : scan.sy + 1'b1;
        end else begin
            nx = scan.sx + 1'b1;
            ny = scan.sy;
        end
    end

    // whole bundle registered from the next position, so every field agrees
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            scan    <= '0;
            scan.sy <= `CORDW'(`V_ACTIVE);  // start in vertical blanking
        end else begin
            scan.sx    <= nx;
            scan.sy    <= ny;
            scan.de    <= (nx < `H_ACTIVE) && (ny < `V_ACTIVE);
            scan.hsync <= (nx >= `H_SYNC_START) && (nx < `H_SYNC_END);
            scan.vsync <= (ny >= `V_SYNC_START) && (ny < `V_SYNC_END);
            scan.line  <= (nx == '0);               // blanking rows too
            scan.frame <= (nx == '0) && (ny == '0);
        end
    end

endmodule

`default_nettype wire

/* src/fade_ctrl.sv */
/* fizzle fade controller
   waits a few frames then walks an LFSR over the framebuffer,
   muxing fade writes with image load writes */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module fade_ctrl (
    input  wire logic               clk_sys,
    input  wire logic               rst_n,
    input  wire logic               frame,
    input  wire fizzle_pkg::fb_wr_t img_wr,
    output fizzle_pkg::fb_wr_t      fb_wr,
    output logic                    fade_done
);

    localparam int WAITW = $clog2(`FADE_WAIT + 1);
    localparam int RATEW = $clog2(`FADE_RATE);

    fizzle_pkg::fade_state_e state;
    logic [WAITW-1:0]     wait_cnt;  // frame pulses seen
    logic [RATEW-1:0]     rate_cnt;
    logic [`LFSR_LEN-1:0] lfsr, lfsr_next;
    logic                 step;      // LFSR advances this cycle
    logic                 fade_hit;  // step lands inside the framebuffer

    always_comb begin
        lfsr_next = {lfsr[`LFSR_LEN-2:0], ^(lfsr & `LFSR_TAPS)};  // fibonacci shift
        step      = (state == fizzle_pkg::FADE_RUN) && (rate_cnt == RATEW'(`FADE_RATE - 1));
        fade_hit  = step && ((lfsr - 1'b1) < `FB_PIXELS);  // lfsr is never 0
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state    <= fizzle_pkg::FADE_IDLE;
            wait_cnt <= '0;
            rate_cnt <= '0;
            lfsr     <= `LFSR_LEN'(1);  // seed
            fb_wr    <= '0;
        end else begin
            case (state)
                fizzle_pkg::FADE_IDLE: begin
                    if (frame) begin
                        if (wait_cnt == WAITW'(`FADE_WAIT - 1)) begin
                            state <= fizzle_pkg::FADE_RUN;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                fizzle_pkg::FADE_RUN: begin
                    rate_cnt <= step ? '0 : rate_cnt + 1'b1;
                    if (step) begin
                        lfsr <= lfsr_next;
                        // back at the seed, all 63 states visited
                        if (lfsr_next == `LFSR_LEN'(1)) begin
                            state <= fizzle_pkg::FADE_DONE;
                        end
                    end
                end
                fizzle_pkg::FADE_DONE: state <= fizzle_pkg::FADE_DONE;  // terminal
                default: state <= fizzle_pkg::FADE_IDLE;
            endcase

            // fade write first, image load only while idle
            if (fade_hit) begin
                fb_wr.we   <= 1'b1;
                fb_wr.addr <= `FB_ADDRW'(lfsr - 1'b1);
                fb_wr.cidx <= `CIDXW'(`FADE_CIDX);
            end else if (state == fizzle_pkg::FADE_IDLE) begin
                fb_wr <= img_wr;
            end else begin
                fb_wr.we <= 1'b0;
            end
        end
    end

    assign fade_done = (state == fizzle_pkg::FADE_DONE);

endmodule

`default_nettype wire

/* src/fb_ram.sv */
/* framebuffer memory
   simple dual port, one write port and one registered read port */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module fb_ram (
    input  wire logic                 clk_sys,
    input  wire fizzle_pkg::fb_wr_t   fb_wr,
    input  wire logic [`FB_ADDRW-1:0] rd_addr,
    output logic [`CIDXW-1:0]         rd_cidx
);

    logic [`CIDXW-1:0] mem [`FB_PIXELS];  // colour indices, row major

    always_ff @(posedge clk_sys) begin
        if (fb_wr.we) begin
            mem[fb_wr.addr] <= fb_wr.cidx;
        end
        rd_cidx <= mem[rd_addr];  // old data on a same-address write
    end

endmodule

`default_nettype wire

/* src/fizzle_cfg.svh */
/* fizzle display configuration
   framebuffer geometry, display timing, fade control and colour widths */
`ifndef FIZZLE_CFG_SVH
`define FIZZLE_CFG_SVH

// framebuffer geometry
`define FB_WIDTH      8     // pixels per framebuffer row
`define FB_HEIGHT     4     // framebuffer rows
`define FB_SCALE      2     // pixel and row repeat on screen
`define FB_PIXELS     32    // FB_WIDTH * FB_HEIGHT
`define FB_ADDRW      5     // framebuffer address bits

// colour widths
`define CIDXW         4     // colour index bits
`define CHANW         4     // bits per colour channel

// horizontal timing, in clk_sys cycles
`define H_ACTIVE      16
`define H_TOTAL       28
`define H_SYNC_START  18
`define H_SYNC_END    22

// vertical timing, in lines
`define V_ACTIVE      8
`define V_TOTAL       12
`define V_SYNC_START  9
`define V_SYNC_END    10

`define CORDW         6     // screen coordinate bits

// fizzle fade
`define FADE_WAIT     3     // frames before the fade starts
`define FADE_RATE     20    // cycles per LFSR step
`define FADE_CIDX     7     // index written by the fade
`define LFSR_LEN      6
`define LFSR_TAPS     6'b110000  // x^6 + x^5 + 1, maximal length

`endif

/* src/fizzle_display.sv */
/* fizzle display top level
   timing, fade control, framebuffer, line scaler and palette;
   pix trails the scan position by two cycles */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module fizzle_display (
    input  wire logic               clk_sys,
    input  wire logic               rst_n,
    input  wire fizzle_pkg::fb_wr_t img_wr,   // image load
    input  wire logic               pal_we,
    input  wire logic [`CIDXW-1:0]  pal_idx,
    input  wire fizzle_pkg::rgb_t   pal_rgb,
    output fizzle_pkg::pix_out_t    pix,
    output logic                    fade_done
);

    fizzle_pkg::scan_t    scan;      // from the timing generator
    fizzle_pkg::scan_t    scan_d;    // one cycle behind, with cidx
    fizzle_pkg::fb_wr_t   fb_wr;
    logic [`FB_ADDRW-1:0] rd_addr;
    logic [`CIDXW-1:0]    rd_cidx;
    logic [`CIDXW-1:0]    lb_cidx;   // scaled index stream

    display_timing display_timing_inst (
        .clk_sys,
        .rst_n,
        .scan
    );

    fade_ctrl fade_ctrl_inst (
        .clk_sys,
        .rst_n,
        .frame (scan.frame),
        .img_wr,
        .fb_wr,
        .fade_done
    );

    fb_ram fb_ram_inst (
        .clk_sys,
        .fb_wr,
        .rd_addr,
        .rd_cidx
    );

    line_scaler line_scaler_inst (
        .clk_sys,
        .rst_n,
        .scan_in  (scan),
        .rd_addr,
        .rd_cidx,
        .cidx     (lb_cidx),
        .scan_out (scan_d)
    );

    clut clut_inst (
        .clk_sys,
        .rst_n,
        .pal_we,
        .pal_idx,
        .pal_rgb,
        .cidx    (lb_cidx),
        .scan_in (scan_d),
        .pix
    );

endmodule

`default_nettype wire

/* src/fizzle_pkg.sv */
/* fizzle display types
   scan bundle, colours, framebuffer writes and fade states */
`default_nettype none

`include "fizzle_cfg.svh"

package fizzle_pkg;

    // screen position plus timing flags, one cycle's worth
    typedef struct packed {
        logic [`CORDW-1:0] sx;
        logic [`CORDW-1:0] sy;
        logic              de;     // active area
        logic              hsync;  // active high
        logic              vsync;  // active high
        logic              line;   // start of every row
        logic              frame;  // start of frame
    } scan_t;

    typedef struct packed {
        logic [`CHANW-1:0] r;
        logic [`CHANW-1:0] g;
        logic [`CHANW-1:0] b;
    } rgb_t;

    // parallel video out
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hsync;
        logic vsync;
    } pix_out_t;

    // single framebuffer write
    typedef struct packed {
        logic                 we;
        logic [`FB_ADDRW-1:0] addr;
        logic [`CIDXW-1:0]    cidx;
    } fb_wr_t;

    typedef enum logic [1:0] {
        FADE_IDLE,  // waiting frames, image load open
        FADE_RUN,   // LFSR walk
        FADE_DONE   // every pixel faded
    } fade_state_e;

endpackage

`default_nettype wire

/* src/line_scaler.sv */
/* framebuffer line scaler
   copies the next framebuffer row into a line buffer during horizontal
   blanking and replays each pixel and row FB_SCALE times */
`default_nettype none
`timescale 1ns/10ps

`include "fizzle_cfg.svh"

module line_scaler (
    input  wire logic                 clk_sys,
    input  wire logic                 rst_n,
    input  wire fizzle_pkg::scan_t    scan_in,
    output logic [`FB_ADDRW-1:0]      rd_addr,
    input  wire logic [`CIDXW-1:0]    rd_cidx,
    output logic [`CIDXW-1:0]         cidx,
    output fizzle_pkg::scan_t         scan_out
);

    localparam int XW = $clog2(`FB_WIDTH);

    logic [`CIDXW-1:0]    lbuf [`FB_WIDTH];  // one framebuffer row
    logic [`CORDW-1:0]    ny;                // screen row after this one
    logic                 need;              // ny starts a new framebuffer row
    logic                 pend;              // fill armed for this row's blanking
    logic                 fill_act;
    logic                 cap_vld;           // rd_cidx valid this cycle
    logic [XW-1:0]        fill_x, cap_x;
    logic [XW-1:0]        bx;                // buffer column for sx
    logic [`FB_ADDRW-1:0] base;              // address of the row being filled

    always_comb begin
        ny   = (scan_in.sy == `CORDW'(`V_TOTAL - 1)) ? '0 : scan_in.sy + 1'b1;
        need = (ny % `FB_SCALE == 0) && (ny / `FB_SCALE < `FB_HEIGHT);
        bx   = XW'(scan_in.sx / `FB_SCALE);
    end

    assign rd_addr = base + `FB_ADDRW'(fill_x);

    // fill sequencing, armed on line and run once the active area ends
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            fill_act <= 1'b0;
            cap_vld  <= 1'b0;
            fill_x   <= '0;
            scan_out <= '0;
        end else begin
            if (scan_in.line) begin
                pend <= need;
            end
            if (pend && scan_in.sx == `CORDW'(`H_ACTIVE)) begin
                pend     <= 1'b0;
                fill_act <= 1'b1;
                fill_x   <= '0;
            end else if (fill_act) begin
                fill_x <= fill_x + 1'b1;
                if (fill_x == XW'(`FB_WIDTH - 1)) begin
                    fill_act <= 1'b0;  // last read issued
                end
            end
            cap_vld  <= fill_act;   // ram has one cycle of latency
            scan_out <= scan_in;    // matches the cidx register
        end
    end

    always_ff @(posedge clk_sys) begin
        if (scan_in.line && need) begin
            base <= `FB_ADDRW'(ny / `FB_SCALE * `FB_WIDTH);
        end
        cap_x <= fill_x;
        if (cap_vld) begin
            lbuf[cap_x] <= rd_cidx;
        end
        cidx <= lbuf[bx];  // each entry shown FB_SCALE times
    end

endmodule

`default_nettype wire
